// File: rtl/core_pkg.sv
// word-only memory access, no CSRs, traps or FENCE; unknown opcodes decode to a no-op
package core_pkg;

    localparam int XLEN = 32;

    // ==============================
    // base opcodes
    // ==============================
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_WORD = 3'b010;  // only LW and SW are decoded

    typedef enum logic [4:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_SLL,
        UOP_SLT,
        UOP_SLTU,
        UOP_XOR,
        UOP_SRL,
        UOP_SRA,
        UOP_OR,
        UOP_AND,
        UOP_LUI,
        UOP_AUIPC,
        UOP_JAL,
        UOP_JALR,
        UOP_BRANCH,
        UOP_LOAD,
        UOP_STORE,
        UOP_NOP
    } uop_e;

    typedef enum logic {
        FWD_RF,
        FWD_WB   // take the result being written back in this cycle
    } fwd_sel_e;

    // ==============================
    // stage and bus packets
    // ==============================
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic            valid;
        uop_e            uop;
        logic [2:0]      funct3;   // branch condition
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;      // already the immediate for register-immediate ops
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic            we;
    } exec_pkt_t;

    typedef struct packed {
        logic            we;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } wb_pkt_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic            we;
        logic [XLEN-1:0] wdata;
    } bus_req_t;

endpackage

// File: rtl/bus_arbiter.sv
// two masters with load/store first; a grant is kept until its requester drops req
module bus_arbiter (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       ls_req_i,
    input  core_pkg::bus_req_t         ls_bus_i,
    input  logic                       if_req_i,
    input  core_pkg::bus_req_t         if_bus_i,
    output logic                       ls_ack_o,
    output logic                       if_ack_o,
    output logic [core_pkg::XLEN-1:0]  rdata_o,
    input  logic                       l1b_bekle_i,
    input  logic [core_pkg::XLEN-1:0]  l1b_deger_i,
    output logic                       l1b_chip_select_n_o,
    output logic [core_pkg::XLEN-1:0]  l1b_adres_o,
    output logic                       l1b_yaz_o,
    output logic [core_pkg::XLEN-1:0]  l1b_yaz_deger_o
);
    import core_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_XFER, ST_ACK} state_e;

    state_e          state_q;
    logic            grant_ls_q;
    logic [XLEN-1:0] rdata_q;
    bus_req_t        sel;
    logic            sel_req;

    assign sel     = grant_ls_q ? ls_bus_i : if_bus_i;
    assign sel_req = grant_ls_q ? ls_req_i : if_req_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            grant_ls_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (ls_req_i || if_req_i) begin
                        grant_ls_q <= ls_req_i;   // load/store wins a tie
                        state_q    <= ST_XFER;
                    end
                end
                ST_XFER: if (!l1b_bekle_i) state_q <= ST_ACK;
                ST_ACK:  if (!sel_req) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // read data is sampled on the completing edge and held through the ack phase
    always_ff @(posedge clk_i) begin
        if (state_q == ST_XFER && !l1b_bekle_i) begin
            rdata_q <= l1b_deger_i;
        end
    end

    assign l1b_chip_select_n_o = (state_q != ST_XFER);
    assign l1b_adres_o         = sel.addr;
    assign l1b_yaz_o           = sel.we;
    assign l1b_yaz_deger_o     = sel.wdata;
    assign ls_ack_o            = (state_q == ST_ACK) && grant_ls_q;
    assign if_ack_o            = (state_q == ST_ACK) && !grant_ls_q;
    assign rdata_o             = rdata_q;

endmodule

// File: rtl/fetch_unit.sv
// one word in flight, no prediction; a fetch overtaken by a redirect completes and is dropped
module fetch_unit #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       stall_i,
    input  logic                       flush_i,
    input  logic                       redirect_i,
    input  logic [core_pkg::XLEN-1:0]  target_i,
    input  logic                       ack_i,
    input  logic [core_pkg::XLEN-1:0]  rdata_i,
    output logic                       req_o,
    output core_pkg::bus_req_t         bus_o,
    output core_pkg::fetch_pkt_t       pkt_o
);
    import core_pkg::*;

    logic [XLEN-1:0] pc_q;       // next address to request
    logic [XLEN-1:0] addr_q;     // address of the fetch in flight
    logic            req_q;
    logic            discard_q;
    logic            done;
    logic            launch;
    fetch_pkt_t      live;
    fetch_pkt_t      hold_q;

    assign done   = req_q && ack_i;
    // a new request waits for an empty slot and for the previous ack to fall
    assign launch = !req_q && !hold_q.valid && !ack_i && !redirect_i;

    assign live  = '{valid: done && !discard_q, pc: addr_q, instr: rdata_i};
    assign pkt_o = hold_q.valid ? hold_q : live;
    assign req_o = req_q;
    assign bus_o = '{addr: addr_q, we: 1'b0, wdata: '0};

    always_ff @(posedge clk_i) begin
        if (launch) begin
            addr_q <= pc_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q      <= RESET_PC;
            req_q     <= 1'b0;
            discard_q <= 1'b0;
            hold_q    <= '0;
        end else begin
            if (launch) begin
                req_q <= 1'b1;
            end else if (done) begin
                req_q <= 1'b0;
            end

            if (redirect_i) begin
                pc_q <= target_i;
            end else if (launch) begin
                pc_q <= pc_q + XLEN'(4);
            end

            if (redirect_i && req_q && !ack_i) begin
                discard_q <= 1'b1;   // wrong-path word still on its way
            end else if (done) begin
                discard_q <= 1'b0;
            end

            if (flush_i) begin
                hold_q.valid <= 1'b0;
            end else if (stall_i && live.valid) begin
                hold_q <= live;
            end else if (!stall_i) begin
                hold_q.valid <= 1'b0;  // taken by decode on this edge
            end
        end
    end

endmodule

// File: rtl/decode_regread.sv
// register file has no reset and x0 always reads as zero; LW and SW only for memory
module decode_regread (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  core_pkg::fetch_pkt_t  pkt_i,
    input  core_pkg::wb_pkt_t     wb_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  core_pkg::fwd_sel_e    fwd1_i,
    input  core_pkg::fwd_sel_e    fwd2_i,
    output logic [4:0]            rs1_o,
    output logic [4:0]            rs2_o,
    output core_pkg::exec_pkt_t   pkt_o
);
    import core_pkg::*;

    localparam exec_pkt_t BUBBLE = '{uop: UOP_NOP, default: '0};

    logic [XLEN-1:0] regs_q [1:31];
    logic [31:0]     instr;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;        // instr[30] picks SUB and SRA
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rf1;
    logic [XLEN-1:0] rf2;
    logic [XLEN-1:0] val1;
    logic [XLEN-1:0] val2;
    uop_e            uop;
    logic            writes_rd;
    logic            use_imm;
    exec_pkt_t       pkt_q;

    assign instr  = pkt_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = instr[30];
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: imm = {instr[31:12], 12'b0};
            OPC_JAL:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            OPC_BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            OPC_STORE:  imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            default:    imm = {{21{instr[31]}}, instr[30:20]};
        endcase
    end

    // ==============================
    // micro-op selection
    // ==============================
    always_comb begin
        uop       = UOP_NOP;
        writes_rd = 1'b1;
        use_imm   = 1'b0;
        case (opcode)
            OPC_LUI:   uop = UOP_LUI;
            OPC_AUIPC: uop = UOP_AUIPC;
            OPC_JAL:   uop = UOP_JAL;
            OPC_JALR:  uop = UOP_JALR;
            OPC_BRANCH: begin
                uop       = UOP_BRANCH;
                writes_rd = 1'b0;
            end
            OPC_LOAD:  if (funct3 == F3_WORD) uop = UOP_LOAD;
            OPC_STORE: begin
                writes_rd = 1'b0;
                if (funct3 == F3_WORD) uop = UOP_STORE;
            end
            OPC_OPIMM, OPC_OP: begin
                use_imm = (opcode == OPC_OPIMM);
                case (funct3)
                    3'b000:  uop = (alt && !use_imm) ? UOP_SUB : UOP_ADD;
                    3'b001:  uop = UOP_SLL;
                    3'b010:  uop = UOP_SLT;
                    3'b011:  uop = UOP_SLTU;
                    3'b100:  uop = UOP_XOR;
                    3'b101:  uop = alt ? UOP_SRA : UOP_SRL;
                    3'b110:  uop = UOP_OR;
                    default: uop = UOP_AND;
                endcase
            end
            default: uop = UOP_NOP;
        endcase
        if (uop == UOP_NOP) writes_rd = 1'b0;
    end

    // operands from the file, or the result execute writes back this cycle
    assign rf1  = (rs1_o == 5'd0) ? '0 : regs_q[rs1_o];
    assign rf2  = (rs2_o == 5'd0) ? '0 : regs_q[rs2_o];
    assign val1 = (fwd1_i == FWD_WB) ? wb_i.data : rf1;
    assign val2 = (fwd2_i == FWD_WB) ? wb_i.data : rf2;

    always_ff @(posedge clk_i) begin
        if (wb_i.we && wb_i.rd != 5'd0) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pkt_q <= BUBBLE;
        end else if (flush_i) begin
            pkt_q <= BUBBLE;
        end else if (!stall_i) begin
            pkt_q.valid  <= pkt_i.valid;
            pkt_q.uop    <= pkt_i.valid ? uop : UOP_NOP;
            pkt_q.funct3 <= funct3;
            pkt_q.op1    <= val1;
            pkt_q.op2    <= use_imm ? imm : val2;
            pkt_q.imm    <= imm;
            pkt_q.pc     <= pkt_i.pc;
            pkt_q.rd     <= instr[11:7];
            pkt_q.we     <= pkt_i.valid && writes_rd;
        end
    end

    assign pkt_o = pkt_q;

endmodule

// File: rtl/execute_unit.sv
// loads and stores move whole aligned words; the low two address bits are dropped
module execute_unit (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  core_pkg::exec_pkt_t        pkt_i,
    input  logic                       ack_i,
    input  logic [core_pkg::XLEN-1:0]  rdata_i,
    output logic                       req_o,
    output core_pkg::bus_req_t         bus_o,
    output logic                       busy_o,
    output logic                       redirect_o,
    output logic [core_pkg::XLEN-1:0]  target_o,
    output core_pkg::wb_pkt_t          wb_o
);
    import core_pkg::*;

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] link;
    logic [XLEN-1:0] sum_imm;   // a + imm serves JALR and memory addresses
    logic            cond;
    logic            mem_op;
    logic            mem_done;
    logic            req_q;

    assign a       = pkt_i.op1;
    assign b       = pkt_i.op2;
    assign sum_imm = a + pkt_i.imm;
    assign link    = pkt_i.pc + XLEN'(4);

    always_comb begin
        case (pkt_i.uop)
            UOP_ADD:   alu_res = a + b;
            UOP_SUB:   alu_res = a - b;
            UOP_SLL:   alu_res = a << b[4:0];
            UOP_SLT:   alu_res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            UOP_SLTU:  alu_res = {{(XLEN-1){1'b0}}, a < b};
            UOP_XOR:   alu_res = a ^ b;
            UOP_SRL:   alu_res = a >> b[4:0];
            UOP_SRA:   alu_res = $unsigned($signed(a) >>> b[4:0]);
            UOP_OR:    alu_res = a | b;
            UOP_AND:   alu_res = a & b;
            UOP_LUI:   alu_res = pkt_i.imm;
            UOP_AUIPC: alu_res = pkt_i.pc + pkt_i.imm;
            default:   alu_res = '0;
        endcase
    end

    always_comb begin
        case (pkt_i.funct3)
            3'b000:  cond = (a == b);
            3'b001:  cond = (a != b);
            3'b100:  cond = ($signed(a) < $signed(b));
            3'b101:  cond = ($signed(a) >= $signed(b));
            3'b110:  cond = (a < b);
            3'b111:  cond = (a >= b);
            default: cond = 1'b0;
        endcase
    end

    // ==============================
    // control transfer
    // ==============================
    assign redirect_o = pkt_i.valid && (pkt_i.uop == UOP_JAL || pkt_i.uop == UOP_JALR ||
                                        (pkt_i.uop == UOP_BRANCH && cond));
    assign target_o   = (pkt_i.uop == UOP_JALR) ? {sum_imm[XLEN-1:1], 1'b0}
                                                : pkt_i.pc + pkt_i.imm;

    // ==============================
    // load/store handshake
    // ==============================
    assign mem_op   = pkt_i.valid && (pkt_i.uop == UOP_LOAD || pkt_i.uop == UOP_STORE);
    assign mem_done = req_q && ack_i;   // an ack only counts while req is still up

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_q <= 1'b0;
        end else if (req_q) begin
            req_q <= !ack_i;
        end else if (mem_op && !ack_i) begin
            req_q <= 1'b1;
        end
    end

    assign req_o  = req_q;
    assign bus_o  = '{addr:  {sum_imm[XLEN-1:2], 2'b00},
                      we:    pkt_i.uop == UOP_STORE,
                      wdata: b};
    assign busy_o = mem_op && !mem_done;

    // write-back source select
    always_comb begin
        wb_o.we = pkt_i.we && !busy_o;
        wb_o.rd = pkt_i.rd;
        case (pkt_i.uop)
            UOP_LOAD:           wb_o.data = rdata_i;
            UOP_JAL, UOP_JALR:  wb_o.data = link;
            default:            wb_o.data = alu_res;
        endcase
    end

endmodule

// File: rtl/hazard_control.sv
// only one stage follows decode, so every hazard is resolved against the execute packet
module hazard_control (
    input  logic [4:0]          rs1_i,
    input  logic [4:0]          rs2_i,
    input  logic [4:0]          exec_rd_i,
    input  logic                exec_we_i,
    input  logic                busy_i,
    input  logic                redirect_i,
    output logic                stall_o,
    output logic                flush_o,
    output core_pkg::fwd_sel_e  fwd1_o,
    output core_pkg::fwd_sel_e  fwd2_o
);
    import core_pkg::*;

    logic hit1;
    logic hit2;

    // x0 is never forwarded, its writes are dropped
    assign hit1 = exec_we_i && (exec_rd_i != 5'd0) && (rs1_i == exec_rd_i);
    assign hit2 = exec_we_i && (exec_rd_i != 5'd0) && (rs2_i == exec_rd_i);

    assign fwd1_o = hit1 ? FWD_WB : FWD_RF;
    assign fwd2_o = hit2 ? FWD_WB : FWD_RF;

    assign stall_o = busy_i;       // a waiting load or store holds the front end
    assign flush_o = redirect_i;

endmodule

// File: rtl/core_top.sv
// single external word bus shared by fetch and load/store; RESET_PC must be word aligned
module core_top #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       l1b_bekle_i,
    input  logic [core_pkg::XLEN-1:0]  l1b_deger_i,
    output logic                       l1b_chip_select_n_o,
    output logic [core_pkg::XLEN-1:0]  l1b_adres_o,
    output logic                       l1b_yaz_o,
    output logic [core_pkg::XLEN-1:0]  l1b_yaz_deger_o
);
    import core_pkg::*;

    fetch_pkt_t      if_pkt;
    exec_pkt_t       ex_pkt;
    wb_pkt_t         wb;
    bus_req_t        if_bus;
    bus_req_t        ls_bus;
    logic            if_req;
    logic            if_ack;
    logic            ls_req;
    logic            ls_ack;
    logic [XLEN-1:0] bus_rdata;
    logic            busy;
    logic            redirect;
    logic [XLEN-1:0] target;
    logic            stall;
    logic            flush;
    fwd_sel_e        fwd1;
    fwd_sel_e        fwd2;
    logic [4:0]      rs1;
    logic [4:0]      rs2;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall),
        .flush_i    (flush),
        .redirect_i (redirect),
        .target_i   (target),
        .ack_i      (if_ack),
        .rdata_i    (bus_rdata),
        .req_o      (if_req),
        .bus_o      (if_bus),
        .pkt_o      (if_pkt)
    );

    decode_regread u_decode (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .pkt_i   (if_pkt),
        .wb_i    (wb),
        .stall_i (stall),
        .flush_i (flush),
        .fwd1_i  (fwd1),
        .fwd2_i  (fwd2),
        .rs1_o   (rs1),
        .rs2_o   (rs2),
        .pkt_o   (ex_pkt)
    );

    execute_unit u_execute (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .pkt_i      (ex_pkt),
        .ack_i      (ls_ack),
        .rdata_i    (bus_rdata),
        .req_o      (ls_req),
        .bus_o      (ls_bus),
        .busy_o     (busy),
        .redirect_o (redirect),
        .target_o   (target),
        .wb_o       (wb)
    );

    hazard_control u_hazard (
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .exec_rd_i  (ex_pkt.rd),
        .exec_we_i  (ex_pkt.we),
        .busy_i     (busy),
        .redirect_i (redirect),
        .stall_o    (stall),
        .flush_o    (flush),
        .fwd1_o     (fwd1),
        .fwd2_o     (fwd2)
    );

    bus_arbiter u_arbiter (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .ls_req_i            (ls_req),
        .ls_bus_i            (ls_bus),
        .if_req_i            (if_req),
        .if_bus_i            (if_bus),
        .ls_ack_o            (ls_ack),
        .if_ack_o            (if_ack),
        .rdata_o             (bus_rdata),
        .l1b_bekle_i         (l1b_bekle_i),
        .l1b_deger_i         (l1b_deger_i),
        .l1b_chip_select_n_o (l1b_chip_select_n_o),
        .l1b_adres_o         (l1b_adres_o),
        .l1b_yaz_o           (l1b_yaz_o),
        .l1b_yaz_deger_o     (l1b_yaz_deger_o)
    );

endmodule

// File: bench/tb_clock_gen.sv
// free-running 8 ns clock; reset is asserted just after time zero and held for three rising edges
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b1;
        #1 rst_n_o = 1'b0;   // a real falling edge so the async resets fire
        repeat (3) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: bench/tb_bus_checker.sv
// stores are compared in order against the expected list; reads are only checked for their address
module tb_bus_checker #(
    parameter logic [31:0] RESET_PC = '0
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        cs_n_i,
    input  logic        bekle_i,
    input  logic        yaz_i,
    input  logic [31:0] adres_i,
    input  logic [31:0] yaz_deger_i,
    input  logic [31:0] lo_addr_i,
    input  logic [31:0] hi_addr_i,
    output int          value_errors_o,
    output int          other_errors_o,
    output int          stores_seen_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          value_errors = 0;
    int          other_errors = 0;
    int          stores_seen = 0;
    logic        seen_read = 1'b0;

    assign value_errors_o = value_errors;
    assign other_errors_o = other_errors;
    assign stores_seen_o  = stores_seen;

    task automatic push_expected(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        if (stores_seen >= exp_addr.size()) begin
            other_errors++;
            $display("unexpected extra store of %08h to address %08h", data, addr);
        end else begin
            if (addr !== exp_addr[stores_seen]) begin
                value_errors++;
                $display("ERROR store_%0d_addr expected %08h actual %08h",
                         stores_seen, exp_addr[stores_seen], addr);
            end
            if (data !== exp_data[stores_seen]) begin
                value_errors++;
                $display("ERROR store_%0d_data expected %08h actual %08h",
                         stores_seen, exp_data[stores_seen], data);
            end
        end
        stores_seen++;
    endtask

    task automatic check_read(input logic [31:0] addr);
        if (!seen_read && addr !== RESET_PC) begin
            value_errors++;
            $display("ERROR first_fetch expected %08h actual %08h", RESET_PC, addr);
        end
        seen_read = 1'b1;
        if (addr < lo_addr_i || addr > hi_addr_i) begin
            other_errors++;
            $display("bus read at %08h lies outside the loaded memory range", addr);
        end
    endtask

    // ==============================
    // sampling on the completing edge
    // ==============================
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            if (cs_n_i !== 1'b1) begin
                other_errors++;
                $display("chip select was not high during reset at %0t", $time);
            end
        end else if (!cs_n_i && !bekle_i) begin
            if (yaz_i) check_store(adres_i, yaz_deger_i);
            else check_read(adres_i);
        end
    end

endmodule

// File: bench/tb_core.sv
// memory holds 256 words from address zero; the data file is read relative to the project root
module tb_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam int MEM_WORDS = 256;
    localparam int RESET_TIMEOUT = 20;
    localparam int RUN_TIMEOUT = 5000;

    logic        clk;
    logic        rst_n;
    logic        bekle = 1'b1;
    logic [31:0] deger = '0;
    logic        cs_n;
    logic [31:0] adres;
    logic        yaz;
    logic [31:0] yaz_deger;
    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] lo_addr = '1;
    logic [31:0] hi_addr = '0;
    logic        active = 1'b0;
    int          wait_left = 0;
    int          exp_count = 0;
    int          local_errors = 0;
    int          value_errors;
    int          other_errors;
    int          stores_seen;

    tb_clock_gen clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    core_top #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk_i               (clk),
        .rst_n_i             (rst_n),
        .l1b_bekle_i         (bekle),
        .l1b_deger_i         (deger),
        .l1b_chip_select_n_o (cs_n),
        .l1b_adres_o         (adres),
        .l1b_yaz_o           (yaz),
        .l1b_yaz_deger_o     (yaz_deger)
    );

    tb_bus_checker #(
        .RESET_PC (RESET_PC)
    ) chk (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .cs_n_i         (cs_n),
        .bekle_i        (bekle),
        .yaz_i          (yaz),
        .adres_i        (adres),
        .yaz_deger_i    (yaz_deger),
        .lo_addr_i      (lo_addr),
        .hi_addr_i      (hi_addr),
        .value_errors_o (value_errors),
        .other_errors_o (other_errors),
        .stores_seen_o  (stores_seen)
    );

    task automatic load_testdata();
        int          fd;
        int          n;
        byte         tag;
        logic [31:0] a;
        logic [31:0] d;
        string       line;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hbad0_0000 ^ 32'(i * 4);   // unloaded words carry their own address
        end
        fd = $fopen("bench/core_testdata.txt", "r");
        if (fd == 0) begin
            local_errors++;
            $display("could not open the test data file");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && (line[0] == "P" || line[0] == "S")) begin
                n = $sscanf(line, "%c %h %h", tag, a, d);
                if (tag == "P" && a < MEM_WORDS * 4) begin
                    mem[a[9:2]] = d;
                    if (a < lo_addr) lo_addr = a;
                    if (a > hi_addr) hi_addr = a;
                end else if (tag == "S") begin
                    chk.push_expected(a, d);
                    exp_count++;
                end else begin
                    local_errors++;
                    $display("program word at %08h does not fit the memory model", a);
                end
            end
        end
        $fclose(fd);
    endtask

    // ==============================
    // memory model with random wait states
    // ==============================
    initial begin
        int w;
        w = $urandom(32'h8e90fc47);
        forever begin
            @(posedge clk);
            if (rst_n && !cs_n) begin
                if (!bekle) begin
                    if (yaz) mem[adres[9:2]] <= yaz_deger;
                    bekle  <= 1'b1;
                    active <= 1'b0;
                end else if (!active) begin
                    w = $urandom % 4;
                    active    <= 1'b1;
                    deger     <= mem[adres[9:2]];
                    wait_left <= w;
                    if (w == 0) bekle <= 1'b0;
                end else begin
                    if (wait_left <= 1) bekle <= 1'b0;
                    wait_left <= wait_left - 1;
                end
            end
        end
    end

    initial begin
        int cycles;
        load_testdata();
        cycles = 0;
        while (!rst_n && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!rst_n) begin
            local_errors++;
            $display("reset was never released");
        end
        cycles = 0;
        while (stores_seen < exp_count && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (stores_seen < exp_count) begin
            local_errors++;
            $display("timeout: only %0d of %0d expected stores were seen", stores_seen, exp_count);
        end
        repeat (20) @(posedge clk);   // room for a wrong-path store to show up
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors + local_errors);
        if (value_errors == 0 && other_errors == 0 && local_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: bench/core_testdata.txt
# P <word address hex> <instruction or data word hex>
# S <store address hex> <expected store data hex>, listed in bus order
P 00000100 00500093
P 00000104 00708113
P 00000108 402081B3
P 0000010C 20302023
P 00000110 00309213
P 00000114 0041C2B3
P 00000118 20502223
P 0000011C 800000B7
P 00000120 4040D313
P 00000124 006033B3
P 00000128 20602423
P 0000012C 20702623
P 00000130 06300013
P 00000134 20002823
P 00000138 12300093
P 0000013C 20102A23
P 00000140 21402083
P 00000144 00108493
P 00000148 20902C23
P 0000014C 00300513
P 00000150 00300593
P 00000154 00B50463
P 00000158 2EA02823
P 0000015C 00A5C463
P 00000160 20B02E23
P 00000164 00C0066F
P 00000168 2EC02823
P 0000016C 2EC02A23
P 00000170 22C02023
P 00000174 18400093
P 00000178 000086E7
P 0000017C 2ED02823
P 00000180 2ED02A23
P 00000184 22D02223
P 00000188 00001717
P 0000018C 22E02423
P 00000190 0000006F
P 00000194 00000013
P 00000198 00000013
P 00000228 00000000
S 00000200 FFFFFFF9
S 00000204 FFFFFFD1
S 00000208 F8000000
S 0000020C 00000001
S 00000210 00000000
S 00000214 00000123
S 00000218 00000124
S 0000021C 00000003
S 00000220 00000168
S 00000224 0000017C
S 00000228 00001188

// File: sources.f
rtl/core_pkg.sv
rtl/bus_arbiter.sv
rtl/fetch_unit.sv
rtl/decode_regread.sv
rtl/execute_unit.sv
rtl/hazard_control.sv
rtl/core_top.sv
bench/tb_clock_gen.sv
bench/tb_bus_checker.sv
bench/tb_core.sv

// File: Bender.yml
package:
  name: rv32i_core

sources:
  - rtl/core_pkg.sv
  - rtl/bus_arbiter.sv
  - rtl/fetch_unit.sv
  - rtl/decode_regread.sv
  - rtl/execute_unit.sv
  - rtl/hazard_control.sv
  - rtl/core_top.sv
  - target: simulation
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_bus_checker.sv
      - bench/tb_core.sv
